//--- src.f
lsu_pkg.sv
lsu_op_if.sv
lsu_rsp_if.sv
lsu_decode.sv
lsu_mem_access.sv
lsu_result.sv
lsu_top.sv
tb_mem_model.sv
tb_lsu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the load/store unit simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu_top -f src.f -o sim_lsu

./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_lsu_top.sv
// Load/store unit testbench
`default_nettype none

module tb_lsu_top
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic clk, rst, invalidate, pause, mem_hung, wb_random;
  logic req_valid, req_ready;
  lsu_cmd_e req_cmd;
  logic [XLEN-1:0] req_base, req_offset, req_store_data;
  logic [TAG_WIDTH-1:0] req_tag, next_tag;
  logic wb_valid, wb_ready;
  logic [XLEN-1:0] wb_result;
  logic [TAG_WIDTH-1:0] wb_tag;
  lsu_fault_e wb_fault;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [XLEN-1:0] awaddr, wdata, araddr, rdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic [RESP_WIDTH-1:0] bresp, rresp;

  logic [XLEN-1:0] shadow [256];
  logic [TAG_WIDTH+XLEN+1:0] exp_q [$];  // {tag, fault, result}
  logic [31:0] rng, wb_rng;

  lsu_top i_lsu_top (.*);

  tb_mem_model i_mem (.*, .hung(mem_hung));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic is_misaligned(lsu_cmd_e cmd, logic [XLEN-1:0] addr);
    case (cmd)
      LH, LHU, SH: return addr[0];
      LW, SW: return addr[1:0] != 2'b00;
      default: return 1'b0;
    endcase
  endfunction

  // Expected {fault, result} from the shadow memory
  function automatic logic [XLEN+1:0] expected_result(lsu_cmd_e cmd, logic [XLEN-1:0] addr);
    logic [XLEN-1:0] w;
    logic [7:0] b;
    logic [15:0] h;
    w = shadow[addr[9:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    if (is_misaligned(cmd, addr)) return {2'(FAULT_MISALIGNED), 32'h0};
    if (addr[15]) return {2'(FAULT_BUS), 32'h0};
    case (cmd)
      LB: return {2'(FAULT_NONE), {24{b[7]}}, b};
      LBU: return {2'(FAULT_NONE), 24'h0, b};
      LH: return {2'(FAULT_NONE), {16{h[15]}}, h};
      LHU: return {2'(FAULT_NONE), 16'h0, h};
      LW: return {2'(FAULT_NONE), w};
      default: return {2'(FAULT_NONE), 32'h0};  // Stores
    endcase
  endfunction

  task automatic update_shadow(lsu_cmd_e cmd, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
    if (is_store(cmd) && !is_misaligned(cmd, addr) && !addr[15]) begin
      case (cmd)
        SB: shadow[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
        SH: shadow[addr[9:2]][16*addr[1] +: 16] = data[15:0];
        default: shadow[addr[9:2]] = data;
      endcase
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) abort_run($sformatf("ERR %s: got %08h expected %08h", name, got, exp));
  endtask

  // Dropped requests are expected to vanish through invalidate
  task automatic send(lsu_cmd_e cmd, logic [XLEN-1:0] base, logic [XLEN-1:0] offset,
                      logic [XLEN-1:0] data, bit dropped);
    logic [XLEN-1:0] addr;
    int cnt;
    addr = base + offset;
    if (!dropped) begin
      exp_q.push_back({next_tag, expected_result(cmd, addr)});
      update_shadow(cmd, addr, data);
    end
    @(posedge clk);
    req_valid <= 1'b1;
    req_cmd <= cmd;
    req_base <= base;
    req_offset <= offset;
    req_store_data <= data;
    req_tag <= next_tag;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > 1000) abort_run("request was not accepted in time");
    end while (!req_ready);
    req_valid <= 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      cnt++;
      if (cnt > 5000) abort_run("write-back queue did not drain in time");
    end
  endtask

  initial begin
    wb_ready = 1'b1;
    wb_rng = 32'hfd44_f542;
    forever begin
      @(posedge clk);
      if (wb_random) begin
        wb_rng = lcg_step(wb_rng);
        wb_ready <= wb_rng[20];
      end else begin
        wb_ready <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin : compare
    logic [TAG_WIDTH+XLEN+1:0] e;
    if (mem_hung) abort_run("memory model handshake timed out");
    if (!rst && wb_valid && wb_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("write-back arrived with no request pending");
      end else begin
        e = exp_q.pop_front();
        check("wb_tag", 32'(wb_tag), 32'(e[TAG_WIDTH+XLEN+1 -: TAG_WIDTH]));
        check("wb_fault", 32'(wb_fault), 32'(e[XLEN+1:XLEN]));
        check("wb_result", wb_result, e[XLEN-1:0]);
      end
    end
  end

  initial begin
    lsu_cmd_e loads [5];
    logic [31:0] r1, r2;
    logic [XLEN-1:0] base;
    loads = '{LB, LBU, LH, LHU, LW};
    rst = 1'b1;
    invalidate = 1'b0;
    pause = 1'b0;
    wb_random = 1'b0;
    req_valid = 1'b0;
    req_cmd = LB;
    req_base = '0;
    req_offset = '0;
    req_store_data = '0;
    req_tag = '0;
    next_tag = '0;
    rng = 32'hfd44_f542;
    for (int i = 0; i < 256; i++) shadow[i] = 32'h9e37_79b9 * (i + 1);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Outputs idle after reset
    check("wb_valid", 32'(wb_valid), 32'h0);
    check("arvalid", 32'(arvalid), 32'h0);
    check("awvalid", 32'(awvalid), 32'h0);
    check("wvalid", 32'(wvalid), 32'h0);
    check("bready", 32'(bready), 32'h0);
    check("rready", 32'(rready), 32'h0);
    check("req_ready", 32'(req_ready), 32'h1);

    send(SW, 32'h40, 32'h0, 32'h8bad_f00d, 0);
    send(SH, 32'h44, 32'h0, 32'h0000_8001, 0);
    send(SH, 32'h44, 32'h2, 32'h1234_7ffe, 0);
    for (int i = 0; i < 4; i++) send(SB, 32'h48, 32'(i), 32'h7f + 32'(i) * 32'h40, 0);
    for (int w = 0; w < 3; w++) begin
      for (int c = 0; c < 5; c++) begin
        for (int off = 0; off < 4; off++) send(loads[c], 32'h40 + 32'(4 * w), 32'(off), '0, 0);
      end
    end
    drain();

    // Misaligned stores must leave memory alone
    send(SH, 32'h50, 32'h1, 32'hdead_beef, 0);
    send(SW, 32'h50, 32'h6, 32'hcafe_babe, 0);
    send(LW, 32'h53, 32'h0, '0, 0);
    send(LHU, 32'h57, 32'h0, '0, 0);
    send(LW, 32'h50, 32'h0, '0, 0);
    send(LW, 32'h54, 32'h0, '0, 0);
    drain();

    send(SW, 32'h8010, 32'h0, 32'h1111_2222, 0);
    send(LW, 32'h8010, 32'h0, '0, 0);
    send(LB, 32'h8013, 32'h0, '0, 0);
    send(SB, 32'h8011, 32'h0, 32'h55, 0);
    drain();

    wb_random <= 1'b1;
    repeat (200) begin
      rng = lcg_step(rng);
      r1 = rng;
      rng = lcg_step(rng);
      r2 = rng;
      base = (r1 & 32'h3fc) | ((r1[31:29] == 3'b111) ? 32'h8000 : 32'h0);
      rng = lcg_step(rng);
      send(lsu_cmd_e'(r2[10:8]), base, 32'(r2[3:0]) - 32'd4, rng, 0);
    end
    drain();
    wb_random <= 1'b0;

    // Second request is held in decode, then invalidated
    @(posedge clk);
    pause <= 1'b1;
    send(LW, 32'h40, 32'h0, '0, 0);
    repeat (3) @(posedge clk);
    send(LW, 32'h44, 32'h0, '0, 1);
    @(posedge clk);
    invalidate <= 1'b1;
    @(posedge clk);
    invalidate <= 1'b0;
    repeat (3) @(posedge clk);
    pause <= 1'b0;
    drain();
    send(LW, 32'h48, 32'h0, '0, 0);
    drain();

    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run("expected write-backs are still pending at the end");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// Testbench memory responder
`default_nettype none

module tb_mem_model
  import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pause,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [XLEN-1:0]       awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [XLEN-1:0]       wdata,
  input  logic [STRB_WIDTH-1:0] wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [RESP_WIDTH-1:0] bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [XLEN-1:0]       araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [XLEN-1:0]       rdata,
  output logic [RESP_WIDTH-1:0] rresp,
  output logic                  hung
);

  timeunit 1ns;
  timeprecision 1ps;

  mem_word_u mem [256];
  logic [31:0] rng;
  logic awready_q, wready_q, bvalid_q, arready_q, rvalid_q;

  // Pause masks every handshake output
  assign awready = awready_q && !pause;
  assign wready = wready_q && !pause;
  assign bvalid = bvalid_q && !pause;
  assign arready = arready_q && !pause;
  assign rvalid = rvalid_q && !pause;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_stall();
    int n;
    rng = lcg_step(rng);
    n = int'(rng[17:16]);  // 0 to 3 cycles
    repeat (n) @(posedge clk);
  endtask

  task automatic serve_read();
    logic [XLEN-1:0] addr;
    int cnt;
    addr = araddr;
    random_stall();
    arready_q <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!(arvalid && arready) && cnt < 2000);
    arready_q <= 1'b0;
    if (cnt >= 2000) hung <= 1'b1;
    random_stall();
    rdata <= addr[15] ? '0 : mem[addr[9:2]];
    rresp <= addr[15] ? 2'd2 : BRESP_OKAY;  // Error region
    rvalid_q <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!(rvalid && rready) && cnt < 2000);
    rvalid_q <= 1'b0;
    if (cnt >= 2000) hung <= 1'b1;
  endtask

  task automatic serve_write();
    logic [XLEN-1:0] addr, data;
    logic [STRB_WIDTH-1:0] strb;
    int cnt;
    addr = awaddr;
    data = wdata;
    strb = wstrb;
    random_stall();
    awready_q <= 1'b1;
    wready_q <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!(awvalid && awready && wvalid && wready) && cnt < 2000);
    awready_q <= 1'b0;
    wready_q <= 1'b0;
    if (cnt >= 2000) hung <= 1'b1;
    if (!addr[15]) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) mem[addr[9:2]].bytes[b] = data[8*b +: 8];
      end
    end
    random_stall();
    bresp <= addr[15] ? 2'd2 : BRESP_OKAY;
    bvalid_q <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!(bvalid && bready) && cnt < 2000);
    bvalid_q <= 1'b0;
    if (cnt >= 2000) hung <= 1'b1;
  endtask

  initial begin
    rng = 32'hfd44_f542;
    for (int i = 0; i < 256; i++) mem[i] = 32'h9e37_79b9 * (i + 1);
    awready_q = 1'b0;
    wready_q = 1'b0;
    bvalid_q = 1'b0;
    arready_q = 1'b0;
    rvalid_q = 1'b0;
    bresp = '0;
    rresp = '0;
    rdata = '0;
    hung = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && arvalid) serve_read();
      else if (!rst && awvalid && wvalid) serve_write();
    end
  end

endmodule

`default_nettype wire

//--- lsu_top.sv
// Load/store unit top level
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  invalidate,

  // From dispatch
  input  logic                  req_valid,
  output logic                  req_ready,
  input  lsu_cmd_e              req_cmd,
  input  logic [XLEN-1:0]       req_base,
  input  logic [XLEN-1:0]       req_offset,
  input  logic [XLEN-1:0]       req_store_data,
  input  logic [TAG_WIDTH-1:0]  req_tag,

  // To write-back
  output logic                  wb_valid,
  input  logic                  wb_ready,
  output logic [XLEN-1:0]       wb_result,
  output logic [TAG_WIDTH-1:0]  wb_tag,
  output lsu_fault_e            wb_fault,

  // Memory port
  output logic                  awvalid,
  input  logic                  awready,
  output logic [XLEN-1:0]       awaddr,
  output logic                  wvalid,
  input  logic                  wready,
  output logic [XLEN-1:0]       wdata,
  output logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  bvalid,
  output logic                  bready,
  input  logic [RESP_WIDTH-1:0] bresp,
  output logic                  arvalid,
  input  logic                  arready,
  output logic [XLEN-1:0]       araddr,
  input  logic                  rvalid,
  output logic                  rready,
  input  logic [XLEN-1:0]       rdata,
  input  logic [RESP_WIDTH-1:0] rresp
);

  lsu_op_if op_if ();
  lsu_rsp_if rsp_if ();

  lsu_decode i_decode (
    .clk, .rst, .invalidate,
    .req_valid, .req_ready, .req_cmd, .req_base, .req_offset,
    .req_store_data, .req_tag,
    .op(op_if.src)
  );

  lsu_mem_access i_mem_access (
    .clk, .rst,
    .op(op_if.dst),
    .rsp(rsp_if.src),
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp
  );

  lsu_result i_result (
    .clk, .rst,
    .rsp(rsp_if.dst),
    .wb_valid, .wb_ready, .wb_result, .wb_tag, .wb_fault
  );

endmodule

`default_nettype wire

//--- lsu_result.sv
// Load extraction and write-back register
`default_nettype none

module lsu_result
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  lsu_rsp_if.dst               rsp,
  output logic                 wb_valid,
  input  logic                 wb_ready,
  output logic [XLEN-1:0]      wb_result,
  output logic [TAG_WIDTH-1:0] wb_tag,
  output lsu_fault_e           wb_fault
);

  logic wb_valid_q;
  logic [XLEN-1:0] result_q;
  logic [TAG_WIDTH-1:0] tag_q;
  lsu_fault_e fault_q;

  mem_word_u word;
  logic [7:0] byte_v;
  logic [15:0] half_v;
  logic [XLEN-1:0] result;

  assign rsp.ready = !wb_valid_q || wb_ready;

  assign word = rsp.rdata;
  assign byte_v = word.bytes[rsp.byte_off];
  assign half_v = word.halves[rsp.byte_off[OFF_WIDTH-1]];  // Upper or lower half

  always_comb begin
    case (rsp.cmd)
      LB: result = XLEN'(signed'(byte_v));
      LBU: result = XLEN'(byte_v);
      LH: result = XLEN'(signed'(half_v));
      LHU: result = XLEN'(half_v);
      default: result = word;  // LW
    endcase
    if (is_store(rsp.cmd) || rsp.fault != FAULT_NONE) result = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_q <= 1'b0;
    end else if (rsp.valid && rsp.ready) begin
      wb_valid_q <= 1'b1;
    end else if (wb_ready) begin
      wb_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp.valid && rsp.ready) begin
      result_q <= result;
      tag_q <= rsp.tag;
      fault_q <= rsp.fault;
    end
  end

  assign wb_valid = wb_valid_q;
  assign wb_result = result_q;
  assign wb_tag = tag_q;
  assign wb_fault = fault_q;

  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_result) && $stable(wb_tag)
      && $stable(wb_fault));

endmodule

`default_nettype wire

//--- lsu_mem_access.sv
// Single-beat memory access FSM
`default_nettype none

module lsu_mem_access
  import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  lsu_op_if.dst                 op,
  lsu_rsp_if.src                rsp,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [XLEN-1:0]       awaddr,
  output logic                  wvalid,
  input  logic                  wready,
  output logic [XLEN-1:0]       wdata,
  output logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  bvalid,
  output logic                  bready,
  input  logic [RESP_WIDTH-1:0] bresp,
  output logic                  arvalid,
  input  logic                  arready,
  output logic [XLEN-1:0]       araddr,
  input  logic                  rvalid,
  output logic                  rready,
  input  logic [XLEN-1:0]       rdata,
  input  logic [RESP_WIDTH-1:0] rresp
);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STORE,
    RESPOND
  } state_e;

  state_e state_q, state_d;
  logic arvalid_q, arvalid_d;
  logic rready_q, rready_d;
  logic awvalid_q, awvalid_d;
  logic wvalid_q, wvalid_d;
  logic bready_q, bready_d;
  logic [XLEN-1:0] rdata_q, rdata_d;
  lsu_fault_e fault_q, fault_d;
  logic [XLEN-1:0] addr_q, wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  lsu_cmd_e cmd_q;
  logic [TAG_WIDTH-1:0] tag_q;
  logic [OFF_WIDTH-1:0] byte_off_q;

  logic op_ack;

  assign op.ready = state_q == IDLE;
  assign op_ack = op.valid && op.ready;

  always_comb begin
    state_d = state_q;
    arvalid_d = arvalid_q;
    rready_d = rready_q;
    awvalid_d = awvalid_q;
    wvalid_d = wvalid_q;
    bready_d = bready_q;
    rdata_d = rdata_q;
    fault_d = fault_q;

    case (state_q)
      IDLE: begin
        if (op.valid) begin
          if (op.misaligned) begin  // No bus traffic
            fault_d = FAULT_MISALIGNED;
            state_d = RESPOND;
          end else if (is_store(op.cmd)) begin
            awvalid_d = 1'b1;
            wvalid_d = 1'b1;
            bready_d = 1'b1;
            state_d = STORE;
          end else begin
            arvalid_d = 1'b1;
            rready_d = 1'b1;
            state_d = LOAD;
          end
        end
      end
      LOAD: begin
        if (arready) arvalid_d = 1'b0;
        if (rvalid) begin
          rready_d = 1'b0;
          rdata_d = rdata;
          fault_d = rresp == BRESP_OKAY ? FAULT_NONE : FAULT_BUS;
          state_d = RESPOND;
        end
      end
      STORE: begin
        if (awready) awvalid_d = 1'b0;
        if (wready) wvalid_d = 1'b0;
        if (bvalid) begin
          bready_d = 1'b0;
          fault_d = bresp == BRESP_OKAY ? FAULT_NONE : FAULT_BUS;
          state_d = RESPOND;
        end
      end
      RESPOND: if (rsp.ready) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      arvalid_q <= 1'b0;
      rready_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q <= 1'b0;
      bready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      arvalid_q <= arvalid_d;
      rready_q <= rready_d;
      awvalid_q <= awvalid_d;
      wvalid_q <= wvalid_d;
      bready_q <= bready_d;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata_d;
    fault_q <= fault_d;
    if (op_ack) begin
      addr_q <= {op.addr[XLEN-1:OFF_WIDTH], OFF_WIDTH'(0)};  // Word aligned on the bus
      wdata_q <= op.wdata;
      wstrb_q <= op.wstrb;
      cmd_q <= op.cmd;
      tag_q <= op.tag;
      byte_off_q <= op.addr[OFF_WIDTH-1:0];
    end
  end

  assign awvalid = awvalid_q;
  assign awaddr = addr_q;
  assign wvalid = wvalid_q;
  assign wdata = wdata_q;
  assign wstrb = wstrb_q;
  assign bready = bready_q;
  assign arvalid = arvalid_q;
  assign araddr = addr_q;
  assign rready = rready_q;

  assign rsp.valid = state_q == RESPOND;
  assign rsp.cmd = cmd_q;
  assign rsp.byte_off = byte_off_q;
  assign rsp.rdata = rdata_q;
  assign rsp.tag = tag_q;
  assign rsp.fault = fault_q;

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr));
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

`default_nettype wire

//--- lsu_decode.sv
// Address generation and store formatting
`default_nettype none

module lsu_decode
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 invalidate,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  lsu_cmd_e             req_cmd,
  input  logic [XLEN-1:0]      req_base,
  input  logic [XLEN-1:0]      req_offset,
  input  logic [XLEN-1:0]      req_store_data,
  input  logic [TAG_WIDTH-1:0] req_tag,
  lsu_op_if.src                op
);

  logic valid_q;
  lsu_cmd_e cmd_q;
  logic [XLEN-1:0] addr_q, wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic [TAG_WIDTH-1:0] tag_q;
  logic misaligned_q;

  logic req_ack;
  logic [XLEN-1:0] eff_addr, wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic misaligned;

  assign req_ready = !valid_q || op.ready;  // Empty, or drained this cycle
  assign req_ack = req_valid && req_ready;
  assign eff_addr = req_base + req_offset;

  always_comb begin
    misaligned = 1'b0;
    wdata = req_store_data;
    case (req_cmd)
      LB, LBU, SB: begin
        wstrb = STRB_WIDTH'(1) << eff_addr[OFF_WIDTH-1:0];
        wdata = {(XLEN / 8){req_store_data[7:0]}};
      end
      LH, LHU, SH: begin
        misaligned = eff_addr[0];
        wstrb = STRB_WIDTH'(3) << {eff_addr[OFF_WIDTH-1], 1'b0};
        wdata = {(XLEN / 16){req_store_data[15:0]}};
      end
      default: begin  // LW, SW
        misaligned = eff_addr[OFF_WIDTH-1:0] != '0;
        wstrb = '1;
      end
    endcase
    if (!is_store(req_cmd)) wstrb = '0;  // Loads never write
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (req_ack) begin
      valid_q <= 1'b1;  // A new request survives invalidate
    end else if (invalidate || op.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ack) begin
      cmd_q <= req_cmd;
      addr_q <= eff_addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
      tag_q <= req_tag;
      misaligned_q <= misaligned;
    end
  end

  assign op.valid = valid_q;
  assign op.cmd = cmd_q;
  assign op.addr = addr_q;
  assign op.wdata = wdata_q;
  assign op.wstrb = wstrb_q;
  assign op.tag = tag_q;
  assign op.misaligned = misaligned_q;

endmodule

`default_nettype wire

//--- lsu_rsp_if.sv
// Raw memory response channel
`default_nettype none

interface lsu_rsp_if
  import lsu_pkg::*;
();

  logic valid;
  logic ready;
  lsu_cmd_e cmd;
  logic [OFF_WIDTH-1:0] byte_off;
  logic [XLEN-1:0] rdata;
  logic [TAG_WIDTH-1:0] tag;
  lsu_fault_e fault;

  modport src(output valid, cmd, byte_off, rdata, tag, fault, input ready);
  modport dst(input valid, cmd, byte_off, rdata, tag, fault, output ready);

endinterface

`default_nettype wire

//--- lsu_op_if.sv
// Decoded operation channel
`default_nettype none

interface lsu_op_if
  import lsu_pkg::*;
();

  logic valid;
  logic ready;
  lsu_cmd_e cmd;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic [TAG_WIDTH-1:0] tag;
  logic misaligned;

  modport src(output valid, cmd, addr, wdata, wstrb, tag, misaligned, input ready);
  modport dst(input valid, cmd, addr, wdata, wstrb, tag, misaligned, output ready);

endinterface

`default_nettype wire

//--- lsu_pkg.sv
// Load/store unit shared definitions
`default_nettype none

package lsu_pkg;

  localparam int XLEN = 32;
  localparam int TAG_WIDTH = 5;
  localparam int STRB_WIDTH = XLEN / 8;
  localparam int OFF_WIDTH = $clog2(STRB_WIDTH);  // Byte offset within a word
  localparam int RESP_WIDTH = 2;

  localparam logic [RESP_WIDTH-1:0] BRESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } lsu_cmd_e;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_MISALIGNED,
    FAULT_BUS
  } lsu_fault_e;

  // One memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [STRB_WIDTH-1:0][7:0] bytes;
    logic [STRB_WIDTH/2-1:0][15:0] halves;
  } mem_word_u;

  function automatic logic is_store(lsu_cmd_e cmd);
    return cmd inside {SB, SH, SW};
  endfunction

endpackage

`default_nettype wire
